/* common/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Datapath and field widths
`define RV_XLEN       32
`define RV_REG_AW     5
`define RV_OPC_W      7
`define RV_F3_W       3
`define RV_SHAMT_W    5

// First fetch address
`define RV_RESET_PC   32'h0000_0000

// Data RAM geometry in words
`define RV_DMEM_WORDS 256
`define RV_DMEM_AW    8

// Writeback source
`define RV_WB_MEM     2'd0
`define RV_WB_ALU     2'd1
`define RV_WB_PC4     2'd2

// Base opcodes
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP     7'b0110011

`endif

/* common/rv_pkg.sv */
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

    //////////////////////////////
    // Instruction formats
    //////////////////////////////
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_F3_W-1:0]    funct3;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_OPC_W-1:0]   opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_F3_W-1:0]    funct3;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_OPC_W-1:0]   opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_F3_W-1:0]    funct3;
        logic [4:0]             imm_lo;
        logic [`RV_OPC_W-1:0]   opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_F3_W-1:0]    funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [`RV_OPC_W-1:0]   opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_OPC_W-1:0]   opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10_1;
        logic                   imm11;
        logic [7:0]             imm19_12;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_OPC_W-1:0]   opcode;
    } j_fmt_t;

    // One word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    //////////////////////////////
    // Control and stage records
    //////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        alu_op_e                alu_op;
        logic                   a_sel;      // 1 picks the PC
        logic                   b_sel;      // 1 picks the immediate
        logic [`RV_F3_W-1:0]    br_cond;
        logic                   is_branch;
        logic                   is_jal;
        logic                   is_jalr;
        logic                   mem_we;
        logic                   mem_re;
        logic                   reg_we;
        logic [1:0]             wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        instr_u                 instr;
        logic [`RV_XLEN-1:0]    rs1_val;
        logic [`RV_XLEN-1:0]    rs2_val;
        logic [`RV_XLEN-1:0]    imm;
        ctrl_t                  ctrl;
    } id_x_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_XLEN-1:0]    result;
        ctrl_t                  ctrl;
    } x_wb_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_XLEN-1:0]    data;
        logic                   reg_we;
    } retire_t;

    typedef enum logic [1:0] {
        FWD_RF, FWD_X, FWD_WB
    } fwd_sel_e;

endpackage

`default_nettype wire

/* execute/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_alu (
    input  wire [`RV_XLEN-1:0]    a,
    input  wire [`RV_XLEN-1:0]    b,
    input  wire rv_pkg::alu_op_e  op,
    output logic [`RV_XLEN-1:0]   y
);

    logic [`RV_SHAMT_W-1:0] shamt;

    assign shamt = b[`RV_SHAMT_W-1:0];

    always_comb begin
        y = '0;
        case (op)
            rv_pkg::ALU_ADD:    y = a + b;
            rv_pkg::ALU_SUB:    y = a - b;
            rv_pkg::ALU_SLL:    y = a << shamt;
            rv_pkg::ALU_SLT:    y[0] = $signed(a) < $signed(b);
            rv_pkg::ALU_SLTU:   y[0] = a < b;
            rv_pkg::ALU_XOR:    y = a ^ b;
            rv_pkg::ALU_SRL:    y = a >> shamt;
            rv_pkg::ALU_SRA:    y = $signed(a) >>> shamt;
            rv_pkg::ALU_OR:     y = a | b;
            rv_pkg::ALU_AND:    y = a & b;
            // LUI
            rv_pkg::ALU_PASS_B: y = b;
            default:            y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* execute/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_execute (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire rv_pkg::id_x_t   id_x,
    input  wire                  fwd_x_a,
    input  wire                  fwd_x_b,
    output logic [`RV_XLEN-1:0]  x_result,
    input  wire [`RV_XLEN-1:0]   wb_result,
    output logic                 redirect,
    output logic [`RV_XLEN-1:0]  redirect_target,
    output logic [`RV_XLEN-1:0]  mem_addr,
    output logic [`RV_XLEN-1:0]  mem_wdata,
    output logic                 mem_we,
    output rv_pkg::x_wb_t        x_wb
);

    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic                cond_true;
    logic                taken;

    // Late bypass for load-use
    assign rs1_val = fwd_x_a ? wb_result : id_x.rs1_val;
    assign rs2_val = fwd_x_b ? wb_result : id_x.rs2_val;

    assign alu_a = id_x.ctrl.a_sel ? id_x.pc  : rs1_val;
    assign alu_b = id_x.ctrl.b_sel ? id_x.imm : rs2_val;

    rv_alu u_alu (
        .a  (alu_a),
        .b  (alu_b),
        .op (id_x.ctrl.alu_op),
        .y  (alu_y)
    );

    // Branch condition on funct3
    always_comb begin
        case (id_x.ctrl.br_cond)
            3'b000:  cond_true = rs1_val == rs2_val;
            3'b001:  cond_true = rs1_val != rs2_val;
            3'b100:  cond_true = $signed(rs1_val) <  $signed(rs2_val);
            3'b101:  cond_true = $signed(rs1_val) >= $signed(rs2_val);
            3'b110:  cond_true = rs1_val <  rs2_val;
            3'b111:  cond_true = rs1_val >= rs2_val;
            default: cond_true = 1'b0;
        endcase
    end

    assign taken           = id_x.valid && id_x.ctrl.is_branch && cond_true;
    assign redirect        = taken || (id_x.valid && id_x.ctrl.is_jalr);
    assign redirect_target = id_x.ctrl.is_jalr ? {alu_y[`RV_XLEN-1:1], 1'b0} :
                                                 id_x.pc + id_x.imm;

    // Value a younger instruction in ID would read
    assign x_result = (id_x.ctrl.wb_sel == `RV_WB_PC4) ? id_x.pc + 4 : alu_y;

    assign mem_addr  = alu_y;
    assign mem_wdata = rs2_val;
    assign mem_we    = id_x.valid && id_x.ctrl.mem_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_wb.valid <= 1'b0;
        end else begin
            x_wb <= '{valid:  id_x.valid,
                      pc:     id_x.pc,
                      rd:     id_x.ctrl.reg_we ? id_x.instr.r.rd : '0,
                      result: alu_y,
                      ctrl:   id_x.ctrl};
        end
    end

    // The word behind a redirect never reaches X
    killed_word_a: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !id_x.valid)
        else $error("killed word reached X after a redirect");

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_core (
    input  wire                        clk,
    input  wire                        rst_n,
    output logic [`RV_XLEN-1:0]        imem_addr,
    input  wire  [`RV_XLEN-1:0]        imem_rdata,
    output logic                       retire_valid,
    output rv_pkg::retire_t            retire
);

    logic                       jal_taken;
    logic [`RV_XLEN-1:0]        jal_target;
    logic                       redirect;
    logic [`RV_XLEN-1:0]        redirect_target;
    logic                       fetch_valid;
    logic [`RV_XLEN-1:0]        fetch_pc;

    rv_pkg::instr_u             id_instr;
    rv_pkg::ctrl_t              id_ctrl;
    logic [`RV_XLEN-1:0]        id_imm;
    logic [`RV_XLEN-1:0]        rd1;
    logic [`RV_XLEN-1:0]        rd2;
    logic [`RV_XLEN-1:0]        id_rs1_val;
    logic [`RV_XLEN-1:0]        id_rs2_val;
    rv_pkg::fwd_sel_e           fwd_id_a;
    rv_pkg::fwd_sel_e           fwd_id_b;
    logic                       fwd_x_a;
    logic                       fwd_x_b;

    rv_pkg::id_x_t              x_stage;
    logic [`RV_XLEN-1:0]        x_result;
    logic [`RV_XLEN-1:0]        mem_addr;
    logic [`RV_XLEN-1:0]        mem_wdata;
    logic                       mem_we;

    rv_pkg::x_wb_t              wb_stage;
    logic [`RV_XLEN-1:0]        wb_result;
    logic                       rf_we;

    //////////////////////////////
    // IF
    //////////////////////////////
    rv_fetch u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .jal_taken       (jal_taken),
        .jal_target      (jal_target),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pc              (imem_addr),
        .fetch_valid     (fetch_valid),
        .fetch_pc        (fetch_pc)
    );

    //////////////////////////////
    // ID
    //////////////////////////////
    assign id_instr = imem_rdata;

    rv_decode u_decode (
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .instr       (id_instr),
        .kill        (redirect),
        .ctrl        (id_ctrl),
        .imm         (id_imm),
        .jal_taken   (jal_taken),
        .jal_target  (jal_target)
    );

    rv_regfile u_regfile (
        .clk (clk),
        .rs1 (id_instr.r.rs1),
        .rs2 (id_instr.r.rs2),
        .rd1 (rd1),
        .rd2 (rd2),
        .we  (rf_we),
        .wa  (retire.rd),
        .wd  (retire.data)
    );

    rv_forward u_forward (
        .id_rs1   (id_instr.r.rs1),
        .id_rs2   (id_instr.r.rs2),
        .x_stage  (x_stage),
        .wb_stage (wb_stage),
        .fwd_id_a (fwd_id_a),
        .fwd_id_b (fwd_id_b),
        .fwd_x_a  (fwd_x_a),
        .fwd_x_b  (fwd_x_b)
    );

    // Operand bypass into the ID/X register
    assign id_rs1_val = (fwd_id_a == rv_pkg::FWD_X)  ? x_result  :
                        (fwd_id_a == rv_pkg::FWD_WB) ? wb_result : rd1;
    assign id_rs2_val = (fwd_id_b == rv_pkg::FWD_X)  ? x_result  :
                        (fwd_id_b == rv_pkg::FWD_WB) ? wb_result : rd2;

    // ID/X register where the younger word dies on a redirect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_stage.valid <= 1'b0;
        end else begin
            x_stage <= '{valid:   fetch_valid && !redirect,
                         pc:      fetch_pc,
                         instr:   id_instr,
                         rs1_val: id_rs1_val,
                         rs2_val: id_rs2_val,
                         imm:     id_imm,
                         ctrl:    id_ctrl};
        end
    end

    //////////////////////////////
    // X
    //////////////////////////////
    rv_execute u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_x            (x_stage),
        .fwd_x_a         (fwd_x_a),
        .fwd_x_b         (fwd_x_b),
        .x_result        (x_result),
        .wb_result       (wb_result),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_we          (mem_we),
        .x_wb            (wb_stage)
    );

    //////////////////////////////
    // WB
    //////////////////////////////
    rv_data_mem u_data_mem (
        .clk          (clk),
        .addr         (mem_addr),
        .wdata        (mem_wdata),
        .we           (mem_we),
        .wb           (wb_stage),
        .wb_result    (wb_result),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    // x0 writes retire but never reach the array
    assign rf_we = retire_valid && retire.reg_we && (retire.rd != '0);

endmodule

`default_nettype wire

/* hdl/rv_data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_data_mem (
    input  wire                  clk,
    input  wire [`RV_XLEN-1:0]   addr,
    input  wire [`RV_XLEN-1:0]   wdata,
    input  wire                  we,
    input  wire rv_pkg::x_wb_t   wb,
    output logic [`RV_XLEN-1:0]  wb_result,
    output logic                 retire_valid,
    output rv_pkg::retire_t      retire
);

    logic [`RV_XLEN-1:0]    ram [`RV_DMEM_WORDS];
    logic [`RV_DMEM_AW-1:0] idx;
    logic [`RV_XLEN-1:0]    rdata;

    // Word index with the byte offset dropped
    assign idx = addr[`RV_DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            ram[idx] <= wdata;
        end
        rdata <= ram[idx];
    end

    always_comb begin
        case (wb.ctrl.wb_sel)
            `RV_WB_MEM: wb_result = rdata;
            `RV_WB_PC4: wb_result = wb.pc + 4;
            default:    wb_result = wb.result;
        endcase
    end

    // Trace record
    assign retire_valid = wb.valid;
    assign retire       = '{pc:     wb.pc,
                            rd:     wb.rd,
                            data:   wb_result,
                            reg_we: wb.ctrl.reg_we};

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_decode (
    input  wire                  fetch_valid,
    input  wire [`RV_XLEN-1:0]   fetch_pc,
    input  wire rv_pkg::instr_u  instr,
    input  wire                  kill,
    output rv_pkg::ctrl_t        ctrl,
    output logic [`RV_XLEN-1:0]  imm,
    output logic                 jal_taken,
    output logic [`RV_XLEN-1:0]  jal_target
);

    rv_pkg::alu_op_e arith_op;
    logic            alt;

    // Bit 30 selects SUB and SRA
    assign alt = instr.r.funct7[5];

    always_comb begin
        case (instr.r.funct3)
            3'b000:  arith_op = (alt && instr.r.opcode == `RV_OPC_OP) ?
                                rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  arith_op = rv_pkg::ALU_SLL;
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b011:  arith_op = rv_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_pkg::ALU_XOR;
            3'b101:  arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.br_cond = instr.b.funct3;
        imm          = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
        case (instr.r.opcode)
            `RV_OPC_LUI: begin
                ctrl.alu_op = rv_pkg::ALU_PASS_B;
                ctrl.b_sel  = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = `RV_WB_ALU;
                imm         = {instr.u.imm, 12'b0};
            end
            `RV_OPC_AUIPC: begin
                ctrl.a_sel  = 1'b1;
                ctrl.b_sel  = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = `RV_WB_ALU;
                imm         = {instr.u.imm, 12'b0};
            end
            `RV_OPC_JAL: begin
                ctrl.is_jal = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = `RV_WB_PC4;
                imm         = {{(`RV_XLEN-20){instr.j.imm20}}, instr.j.imm19_12,
                               instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            `RV_OPC_JALR: begin
                ctrl.is_jalr = 1'b1;
                ctrl.b_sel   = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_sel  = `RV_WB_PC4;
            end
            `RV_OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                imm            = {{(`RV_XLEN-12){instr.b.imm12}}, instr.b.imm11,
                                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            `RV_OPC_LOAD: begin
                ctrl.b_sel  = 1'b1;
                ctrl.mem_re = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = `RV_WB_MEM;
            end
            `RV_OPC_STORE: begin
                ctrl.b_sel  = 1'b1;
                ctrl.mem_we = 1'b1;
                imm         = {{(`RV_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi,
                               instr.s.imm_lo};
            end
            `RV_OPC_OP_IMM: begin
                ctrl.alu_op = arith_op;
                ctrl.b_sel  = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = `RV_WB_ALU;
            end
            `RV_OPC_OP: begin
                ctrl.alu_op = arith_op;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = `RV_WB_ALU;
            end
            default: begin
                // Unknown opcode falls through as a no-op
                ctrl.br_cond = '0;
            end
        endcase
    end

    // JAL resolves here and costs one slot
    assign jal_taken  = fetch_valid && !kill && ctrl.is_jal;
    assign jal_target = fetch_pc + imm;

endmodule

`default_nettype wire

/* hdl/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_fetch (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  jal_taken,
    input  wire [`RV_XLEN-1:0]   jal_target,
    input  wire                  redirect,
    input  wire [`RV_XLEN-1:0]   redirect_target,
    output logic [`RV_XLEN-1:0]  pc,
    output logic                 fetch_valid,
    output logic [`RV_XLEN-1:0]  fetch_pc
);

    logic [`RV_XLEN-1:0] pc_next;

    // X redirect outranks the ID jump
    assign pc_next = redirect  ? redirect_target :
                     jal_taken ? jal_target      : pc + 4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `RV_RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            pc          <= pc_next;
            fetch_valid <= !(redirect || jal_taken);
        end
    end

    // PC of the word now on the instruction port
    always_ff @(posedge clk) begin
        fetch_pc <= pc;
    end

    // A kill leaves a dead word behind, so the next cycle cannot kill again
    single_kill_a: assert property (@(posedge clk) disable iff (!rst_n)
        (jal_taken || redirect) |=> !(jal_taken || redirect))
        else $error("back-to-back kill of one fetch slot");

endmodule

`default_nettype wire

/* hdl/rv_forward.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_forward (
    input  wire [`RV_REG_AW-1:0]  id_rs1,
    input  wire [`RV_REG_AW-1:0]  id_rs2,
    input  wire rv_pkg::id_x_t    x_stage,
    input  wire rv_pkg::x_wb_t    wb_stage,
    output rv_pkg::fwd_sel_e      fwd_id_a,
    output rv_pkg::fwd_sel_e      fwd_id_b,
    output logic                  fwd_x_a,
    output logic                  fwd_x_b
);

    logic [`RV_REG_AW-1:0] x_rd;
    logic                  x_src;
    logic                  wb_src;
    logic                  wb_load;

    assign x_rd = x_stage.instr.r.rd;

    // Load data is not ready while the load sits in X
    assign x_src   = x_stage.valid && x_stage.ctrl.reg_we && !x_stage.ctrl.mem_re &&
                     (x_rd != '0);
    assign wb_src  = wb_stage.valid && wb_stage.ctrl.reg_we && (wb_stage.rd != '0);
    assign wb_load = wb_src && wb_stage.ctrl.mem_re;

    // Younger producer wins
    assign fwd_id_a = (x_src && x_rd == id_rs1)            ? rv_pkg::FWD_X  :
                      (wb_src && wb_stage.rd == id_rs1)    ? rv_pkg::FWD_WB : rv_pkg::FWD_RF;
    assign fwd_id_b = (x_src && x_rd == id_rs2)            ? rv_pkg::FWD_X  :
                      (wb_src && wb_stage.rd == id_rs2)    ? rv_pkg::FWD_WB : rv_pkg::FWD_RF;

    // Load returning in WB patches its direct consumer in X
    assign fwd_x_a = wb_load && (wb_stage.rd == x_stage.instr.r.rs1);
    assign fwd_x_b = wb_load && (wb_stage.rd == x_stage.instr.r.rs2);

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_regfile (
    input  wire                   clk,
    input  wire [`RV_REG_AW-1:0]  rs1,
    input  wire [`RV_REG_AW-1:0]  rs2,
    output logic [`RV_XLEN-1:0]   rd1,
    output logic [`RV_XLEN-1:0]   rd2,
    input  wire                   we,
    input  wire [`RV_REG_AW-1:0]  wa,
    input  wire [`RV_XLEN-1:0]    wd
);

    logic [`RV_XLEN-1:0] regs [1<<`RV_REG_AW];

    // Entry zero is never written
    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    // Writeback filters x0 before the port
    no_x0_write_a: assert property (@(posedge clk) we |-> wa != '0)
        else $error("regfile write aimed at x0");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f tb.f -o sim_tb

if ! out=$(./obj_dir/sim_tb 2>&1); then
    echo "$out"
    exit 1
fi
echo "$out"

echo "$out" | grep -q "Testbench passed"

/* tb.f */
+incdir+common
common/rv_pkg.sv
execute/rv_alu.sv
execute/rv_execute.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_forward.sv
hdl/rv_data_mem.sv
hdl/rv_core.sv
testbench/tb_rv_core.sv

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module tb_rv_core;

    localparam int PROG_LEN = 200;
    localparam int ROM_WORDS = 256;
    localparam int LAST_PC = (PROG_LEN - 1) * 4;

    logic                  clk;
    logic                  rst_n;
    logic [31:0]           imem_addr;
    logic [31:0]           imem_rdata;
    logic                  retire_valid;
    rv_pkg::retire_t       retire;

    logic [31:0]           rom [ROM_WORDS];
    logic [31:0]           addr_q;
    rv_pkg::retire_t       exp_q [$];
    logic                  limit_ready;
    longint                limit_ns;

    rv_core DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #10 clk = ~clk;

    //////////////////////////////
    // Instruction encoders
    //////////////////////////////
    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], `RV_OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OPC_JAL};
    endfunction

    function automatic logic [4:0] pick_reg();
        // Small register pool keeps dependency chains dense
        return 5'($urandom % 8);
    endfunction

    //////////////////////////////
    // Random program
    //////////////////////////////
    task automatic build_program();
        int          i;
        int          kind;
        int          tgt;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  rd;
        for (i = 0; i < ROM_WORDS; i++) begin
            rom[i] = enc_i(12'd0, 5'd0, 3'b000, 5'd0, `RV_OPC_OP_IMM);
        end
        // Every register and the first eight data words get a known value
        for (i = 1; i < 32; i++) begin
            rom[i - 1] = {20'($urandom), 5'(i), `RV_OPC_LUI};
        end
        for (i = 0; i < 8; i++) begin
            rom[31 + i] = enc_s(12'(i * 4), 5'(i + 1));
        end
        i = 39;
        while (i < PROG_LEN - 1) begin
            kind = $urandom % 10;
            f3   = 3'($urandom);
            rd   = pick_reg();
            tgt  = i + 1 + ($urandom % 4);
            if (tgt > PROG_LEN - 1) begin
                tgt = PROG_LEN - 1;
            end
            if (kind <= 2) begin
                imm = 12'($urandom);
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm[11:5] = (f3 == 3'b101 && $urandom % 2 == 1) ? 7'h20 : 7'h00;
                end
                rom[i] = enc_i(imm, pick_reg(), f3, rd, `RV_OPC_OP_IMM);
            end else if (kind <= 4) begin
                rom[i] = enc_r(((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) ?
                               7'h20 : 7'h00, pick_reg(), pick_reg(), f3, rd);
            end else if (kind == 5) begin
                rom[i] = {20'($urandom), rd, ($urandom % 2) ? `RV_OPC_LUI : `RV_OPC_AUIPC};
            end else if (kind == 6) begin
                imm = 12'(($urandom % 8) * 4);
                rom[i] = ($urandom % 2) ? enc_s(imm, pick_reg()) :
                                          enc_i(imm, 5'd0, 3'b010, rd, `RV_OPC_LOAD);
            end else if (kind == 7) begin
                while (f3 == 3'b010 || f3 == 3'b011) begin
                    f3 = 3'($urandom);
                end
                rom[i] = enc_b(13'((tgt - i) * 4), pick_reg(), pick_reg(), f3);
            end else if (kind == 8) begin
                rom[i] = ($urandom % 2) ? enc_j(21'((tgt - i) * 4), rd) :
                         enc_i(12'(tgt * 4), 5'd0, 3'b000, rd, `RV_OPC_JALR);
            end else if (i + 3 < PROG_LEN - 1) begin
                // Store, reload and immediate use
                imm = 12'(($urandom % 8) * 4);
                rom[i]     = enc_s(imm, pick_reg());
                rom[i + 1] = enc_i(imm, 5'd0, 3'b010, rd, `RV_OPC_LOAD);
                rom[i + 2] = enc_r(7'h00, rd, rd, 3'b000, pick_reg());
                i = i + 2;
            end
            i++;
        end
        // Final loop
        rom[PROG_LEN - 1] = enc_j(21'd0, 5'd0);
    endtask

    //////////////////////////////
    // Instruction-set model
    //////////////////////////////
    function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
                                              logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0]     mr [32];
        logic [31:0]     dm [256];
        logic [31:0]     pc;
        logic [31:0]     npc;
        logic [31:0]     w;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     imm_i;
        logic [31:0]     val;
        logic            we;
        logic            take;
        rv_pkg::retire_t rec;
        for (int k = 0; k < 32; k++) begin
            mr[k] = '0;
        end
        pc = 0;
        forever begin
            w     = rom[pc[9:2]];
            a     = mr[w[19:15]];
            b     = mr[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            npc   = pc + 4;
            val   = '0;
            we    = 1'b1;
            case (w[6:0])
                `RV_OPC_LUI:    val = {w[31:12], 12'd0};
                `RV_OPC_AUIPC:  val = pc + {w[31:12], 12'd0};
                `RV_OPC_JAL: begin
                    val = pc + 4;
                    npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                `RV_OPC_JALR: begin
                    val = pc + 4;
                    npc = (a + imm_i) & ~32'd1;
                end
                `RV_OPC_BRANCH: begin
                    we = 1'b0;
                    case (w[14:12])
                        3'b000:  take = a == b;
                        3'b001:  take = a != b;
                        3'b100:  take = $signed(a) < $signed(b);
                        3'b101:  take = $signed(a) >= $signed(b);
                        3'b110:  take = a < b;
                        default: take = a >= b;
                    endcase
                    if (take) begin
                        npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                `RV_OPC_LOAD:   val = dm[8'((a + imm_i) >> 2)];
                `RV_OPC_STORE: begin
                    we = 1'b0;
                    dm[8'((a + {{20{w[31]}}, w[31:25], w[11:7]}) >> 2)] = b;
                end
                `RV_OPC_OP_IMM: val = alu_model(w[14:12], w[14:12] == 3'b101 && w[30], a, imm_i);
                default:        val = alu_model(w[14:12], w[30], a, b);
            endcase
            rec.pc     = pc;
            rec.rd     = w[11:7];
            rec.data   = val;
            rec.reg_we = we;
            exp_q.push_back(rec);
            if (we && w[11:7] != 5'd0) begin
                mr[w[11:7]] = val;
            end
            if (pc == LAST_PC) begin
                break;
            end
            pc = npc;
        end
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Instruction ROM answers one cycle after the address
    always @(posedge clk) begin
        addr_q <= imem_addr;
    end

    always @(negedge clk) begin
        imem_rdata <= (addr_q[31:2] < ROM_WORDS) ? rom[addr_q[9:2]] : 32'h0000_0013;
    end

    always @(negedge clk) begin
        rv_pkg::retire_t e;
        if (retire_valid === 1'b1) begin
            if (!rst_n) begin
                $display("Retire strobe seen while reset was held");
                $display("Testbench failed");
                $fatal(1);
            end else if (exp_q.size() == 0) begin
                $display("Retire strobe with no instruction left in the model");
                $display("Testbench failed");
                $fatal(1);
            end else begin
                e = exp_q.pop_front();
                check("retire.pc", retire.pc, e.pc);
                check("retire.reg_we", 32'(retire.reg_we), 32'(e.reg_we));
                if (e.reg_we) begin
                    check("retire.rd", 32'(retire.rd), 32'(e.rd));
                    check("retire.data", retire.data, e.data);
                end
                if (exp_q.size() == 0) begin
                    $display("Testbench passed");
                    $finish;
                end
            end
        end
    end

    initial begin
        wait (limit_ready);
        #(limit_ns);
        $display("Timed out before the program reached its final loop");
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        imem_rdata  = 32'h0000_0013;
        addr_q      = '0;
        limit_ready = 1'b0;
        void'($urandom(75238));
        build_program();
        run_model();
        limit_ns    = (4 * exp_q.size() + 16) * 20;
        limit_ready = 1'b1;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
